// File: logic/dispatch_pkg.sv
/*
 * dispatch stage definitions
 * buffer index and pc types, instruction classes, functional units and
 * issue slots shared by the buffer, the dispatcher and the unit tracker
 */

package dispatch_pkg;

	// ==============================
	// sizes
	// ==============================

	// default number of reorder buffer entries
	localparam int ROB_ENTRIES = 8;

	// one issue slot per class of functional unit
	localparam int NUM_SLOTS = 4;

	// two ALUs, a shared multiply/divide unit, flow control and memory
	localparam int NUM_UNITS = 5;

	// ==============================
	// scalar types
	// ==============================

	// index into the reorder buffer, wide enough for eight entries
	typedef logic [2:0] rob_ndx_t;

	// program counter carried along for commit and for the units
	typedef logic [15:0] pc_t;

	// ==============================
	// encodings
	// ==============================

	// class of a renamed instruction
	// OC_NOP marks a dispatch that was nullified by stomp or a false predicate
	typedef enum logic [2:0] {
		OC_ALU,
		OC_MUL,
		OC_DIV,
		OC_FC,
		OC_MEM,
		OC_NOP
	} op_class_t;

	// functional units, multiply and divide share one unit
	typedef enum logic [2:0] {
		FU_ALU0,
		FU_ALU1,
		FU_MULDIV,
		FU_FC,
		FU_MEM
	} func_unit_t;

	// issue slots, each one accepts at most one entry per cycle
	typedef enum logic [1:0] {
		SL_ALU,
		SL_MULDIV,
		SL_FC,
		SL_MEM
	} slot_t;

endpackage

// File: logic/reorder_buffer.sv
/*
 * reorder buffer
 * circular buffer of in-flight instructions, allocated in program order,
 * marked out and done by the dispatch and completion paths, committed in order
 */

`timescale 1ns/1ps

module reorder_buffer import dispatch_pkg::*; #(
	parameter int DEPTH = ROB_ENTRIES
) (
	input  logic                      clk,
	input  logic                      rst,
	// allocation at the tail
	input  logic                      alloc_v_i,
	input  op_class_t                 alloc_cls_i,
	input  pc_t                       alloc_pc_i,
	input  logic                      alloc_pred_v_i,
	input  logic                      alloc_pred_i,
	// late predicate resolution
	input  logic                      pred_set_v_i,
	input  rob_ndx_t                  pred_set_ndx_i,
	input  logic                      pred_set_val_i,
	// registered slot records coming back from the dispatcher
	input  logic [NUM_SLOTS-1:0]      disp_v_i,
	input  rob_ndx_t [NUM_SLOTS-1:0]  disp_ndx_i,
	// completion returned by the unit tracker
	input  logic                      done_v_i,
	input  rob_ndx_t                  done_ndx_i,
	output logic                      alloc_ready_o,
	output rob_ndx_t                  head_o,
	output logic [DEPTH-1:0]          rob_v_o,
	output op_class_t [DEPTH-1:0]     rob_cls_o,
	output pc_t [DEPTH-1:0]           rob_pc_o,
	output logic [DEPTH-1:0]          rob_pred_v_o,
	output logic [DEPTH-1:0]          rob_pred_o,
	output logic [DEPTH-1:0]          rob_out_o,
	output logic [DEPTH-1:0]          rob_done_o,
	// commit record, one per cycle at most
	output logic                      commit_v_o,
	output rob_ndx_t                  commit_ndx_o,
	output pc_t                       commit_pc_o
);

	// the count needs one more state than the index to tell full from empty
	localparam int CNT_W = $clog2(DEPTH + 1);

	rob_ndx_t         head_q;
	rob_ndx_t         tail_q;
	logic [CNT_W-1:0] count_q;
	logic             alloc_fire;
	logic             commit_fire;

	// pointers wrap at DEPTH, which is a power of two
	function automatic rob_ndx_t ndx_inc(input rob_ndx_t ndx);
		ndx_inc = rob_ndx_t'((int'(ndx) + 1) % DEPTH);
	endfunction

	// an allocation while full is simply dropped
	assign alloc_ready_o = (count_q != CNT_W'(DEPTH));
	assign alloc_fire = alloc_v_i && alloc_ready_o;

	// the oldest entry retires once its unit has reported completion
	assign commit_fire = rob_v_o[head_q] && rob_done_o[head_q];

	assign head_o = head_q;

	// ==============================
	// control state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			rob_v_o <= '0;
			rob_out_o <= '0;
			rob_done_o <= '0;
			commit_v_o <= 1'b0;
		end else begin
			commit_v_o <= commit_fire;
			// an entry seen on a slot record is out from now on
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (disp_v_i[s])
					rob_out_o[disp_ndx_i[s]] <= 1'b1;
			end
			if (done_v_i)
				rob_done_o[done_ndx_i] <= 1'b1;
			if (commit_fire) begin
				rob_v_o[head_q] <= 1'b0;
				head_q <= ndx_inc(head_q);
			end
			// the tail slot is free here, so its flags start clean
			if (alloc_fire) begin
				rob_v_o[tail_q] <= 1'b1;
				rob_out_o[tail_q] <= 1'b0;
				rob_done_o[tail_q] <= 1'b0;
				tail_q <= ndx_inc(tail_q);
			end
			count_q <= count_q + CNT_W'(alloc_fire) - CNT_W'(commit_fire);
		end
	end

	// ==============================
	// entry payload
	// ==============================

	always_ff @(posedge clk) begin
		if (alloc_fire) begin
			rob_cls_o[tail_q] <= alloc_cls_i;
			rob_pc_o[tail_q] <= alloc_pc_i;
			rob_pred_v_o[tail_q] <= alloc_pred_v_i;
			rob_pred_o[tail_q] <= alloc_pred_i;
		end
		// resolution of a predicate that was unknown at rename
		if (pred_set_v_i) begin
			rob_pred_v_o[pred_set_ndx_i] <= 1'b1;
			rob_pred_o[pred_set_ndx_i] <= pred_set_val_i;
		end
		// commit record follows the head, only qualified by commit_v_o
		commit_ndx_o <= head_q;
		commit_pc_o <= rob_pc_o[head_q];
	end

endmodule

// File: logic/instruction_dispatcher.sv
/*
 * instruction dispatcher
 * scans the reorder buffer oldest first and picks at most one eligible entry
 * per issue slot, then registers the slot records toward the units
 */

`timescale 1ns/1ps

module instruction_dispatcher import dispatch_pkg::*; #(
	parameter int DEPTH = ROB_ENTRIES,
	parameter int SERIALIZE = 0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  rob_ndx_t                    head_i,
	// per-entry state of the buffer
	input  logic [DEPTH-1:0]            rob_v_i,
	input  op_class_t [DEPTH-1:0]       rob_cls_i,
	input  pc_t [DEPTH-1:0]             rob_pc_i,
	input  logic [DEPTH-1:0]            rob_pred_v_i,
	input  logic [DEPTH-1:0]            rob_pred_i,
	input  logic [DEPTH-1:0]            rob_out_i,
	input  logic [DEPTH-1:0]            rob_done_i,
	input  logic [DEPTH-1:0]            stomp_i,
	input  logic [NUM_UNITS-1:0]        unit_busy_i,
	// registered slot records
	output logic [NUM_SLOTS-1:0]        disp_v_o,
	output rob_ndx_t [NUM_SLOTS-1:0]    disp_ndx_o,
	output func_unit_t [NUM_SLOTS-1:0]  disp_unit_o,
	output op_class_t [NUM_SLOTS-1:0]   disp_cls_o,
	output pc_t [NUM_SLOTS-1:0]         disp_pc_o
);

	// selection of the current cycle, registered below
	logic [NUM_SLOTS-1:0]       sel_v;
	rob_ndx_t [NUM_SLOTS-1:0]   sel_ndx;
	func_unit_t [NUM_SLOTS-1:0] sel_unit;
	op_class_t [NUM_SLOTS-1:0]  sel_cls;
	pc_t [NUM_SLOTS-1:0]        sel_pc;

	// every class feeds exactly one slot
	// a NOP allocated as such runs through the ALU slot like any simple op
	function automatic slot_t slot_of(input op_class_t cls);
		case (cls)
			OC_MUL, OC_DIV: slot_of = SL_MULDIV;
			OC_FC:          slot_of = SL_FC;
			OC_MEM:         slot_of = SL_MEM;
			default:        slot_of = SL_ALU;
		endcase
	endfunction

	// ==============================
	// oldest-first scan
	// ==============================

	always_comb begin
		rob_ndx_t   idx;
		rob_ndx_t   prev;
		slot_t      sl;
		func_unit_t fu;
		logic       ok;
		logic       free;

		for (int s = 0; s < NUM_SLOTS; s++) begin
			sel_v[s] = 1'b0;
			sel_ndx[s] = '0;
			sel_unit[s] = FU_ALU0;
			sel_cls[s] = OC_NOP;
			sel_pc[s] = '0;
		end

		// k counts age from the head, so an earlier k always wins a slot
		for (int k = 0; k < DEPTH; k++) begin
			idx = rob_ndx_t'((int'(head_i) + k) % DEPTH);
			prev = rob_ndx_t'((int'(idx) + DEPTH - 1) % DEPTH);

			// valid, not finished, not yet sent and predicate known
			ok = rob_v_i[idx] && !rob_done_i[idx] && !rob_out_i[idx] && rob_pred_v_i[idx];

			// in serial mode the older neighbour has to be done or gone
			// the head has no older neighbour in flight
			if (SERIALIZE != 0 && k != 0)
				ok = ok && (rob_done_i[prev] || !rob_v_i[prev]);

			// the buffer sets out one edge after the slot record appears,
			// so entries on the current records are still shown as not out
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (disp_v_o[s] && disp_ndx_o[s] == idx)
					ok = 1'b0;
			end

			sl = slot_of(rob_cls_i[idx]);

			// find a unit of the class that is not reserved
			case (rob_cls_i[idx])
				OC_MUL, OC_DIV: begin
					fu = FU_MULDIV;
					free = !unit_busy_i[FU_MULDIV];
				end
				OC_FC: begin
					fu = FU_FC;
					free = !unit_busy_i[FU_FC];
				end
				OC_MEM: begin
					fu = FU_MEM;
					free = !unit_busy_i[FU_MEM];
				end
				default: begin
					// ALU0 is preferred, ALU1 takes the overflow
					if (!unit_busy_i[FU_ALU0]) begin
						fu = FU_ALU0;
						free = 1'b1;
					end else begin
						fu = FU_ALU1;
						free = !unit_busy_i[FU_ALU1];
					end
				end
			endcase

			// one entry per slot, and an entry only ever maps to one slot
			if (ok && free && !sel_v[sl]) begin
				sel_v[sl] = 1'b1;
				sel_ndx[sl] = idx;
				sel_unit[sl] = fu;
				sel_pc[sl] = rob_pc_i[idx];
				// stomped or predicated-off work still has to flow through a
				// unit so that its entry completes and commits
				if (stomp_i[idx] || !rob_pred_i[idx])
					sel_cls[sl] = OC_NOP;
				else
					sel_cls[sl] = rob_cls_i[idx];
			end
		end
	end

	// ==============================
	// slot records
	// ==============================

	always_ff @(posedge clk) begin
		if (rst)
			disp_v_o <= '0;
		else
			disp_v_o <= sel_v;
	end

	// record payload is qualified by disp_v_o
	always_ff @(posedge clk) begin
		disp_ndx_o <= sel_ndx;
		disp_unit_o <= sel_unit;
		disp_cls_o <= sel_cls;
		disp_pc_o <= sel_pc;
	end

endmodule

// File: logic/unit_busy_tracker.sv
/*
 * functional unit reservation
 * holds each unit busy from dispatch until it reports completion and
 * returns the buffer index the unit was working on
 */

`timescale 1ns/1ps

module unit_busy_tracker import dispatch_pkg::*; (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [NUM_SLOTS-1:0]        disp_v_i,
	input  func_unit_t [NUM_SLOTS-1:0]  disp_unit_i,
	input  rob_ndx_t [NUM_SLOTS-1:0]    disp_ndx_i,
	input  logic                        complete_v_i,
	input  func_unit_t                  complete_unit_i,
	output logic [NUM_UNITS-1:0]        unit_busy_o,
	output logic                        done_v_o,
	output rob_ndx_t                    done_ndx_o
);

	logic [NUM_UNITS-1:0]     busy_q;
	rob_ndx_t [NUM_UNITS-1:0] held_q;
	// units named by the current slot records and the entries they take
	logic [NUM_UNITS-1:0]     claim;
	rob_ndx_t [NUM_UNITS-1:0] claim_ndx;
	logic                     cmp_ok;

	always_comb begin
		claim = '0;
		claim_ndx = held_q;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (disp_v_i[s]) begin
				claim[disp_unit_i[s]] = 1'b1;
				claim_ndx[disp_unit_i[s]] = disp_ndx_i[s];
			end
		end
	end

	// a claim counts as busy right away so the next scan skips the unit
	assign unit_busy_o = busy_q | claim;

	// a completion from an unknown or idle unit is not passed on
	assign cmp_ok = (int'(complete_unit_i) < NUM_UNITS);
	assign done_v_o = complete_v_i && cmp_ok && unit_busy_o[complete_unit_i];
	assign done_ndx_o = claim_ndx[complete_unit_i];

	// completion wins over a claim arriving at the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= '0;
		end else begin
			for (int u = 0; u < NUM_UNITS; u++) begin
				busy_q[u] <= (busy_q[u] | claim[u]) &
					~(complete_v_i && int'(complete_unit_i) == u);
			end
		end
	end

	always_ff @(posedge clk) begin
		held_q <= claim_ndx;
	end

endmodule

// File: logic/dispatch_top.sv
/*
 * dispatch stage top
 * reorder buffer, dispatcher and unit tracker joined into one stage
 */

`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; #(
	parameter int DEPTH = ROB_ENTRIES,
	parameter int SERIALIZE = 0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        alloc_v_i,
	input  op_class_t                   alloc_cls_i,
	input  pc_t                         alloc_pc_i,
	input  logic                        alloc_pred_v_i,
	input  logic                        alloc_pred_i,
	output logic                        alloc_ready_o,
	input  logic                        pred_set_v_i,
	input  rob_ndx_t                    pred_set_ndx_i,
	input  logic                        pred_set_val_i,
	input  logic [DEPTH-1:0]            stomp_i,
	input  logic                        complete_v_i,
	input  func_unit_t                  complete_unit_i,
	output logic [NUM_SLOTS-1:0]        disp_v_o,
	output rob_ndx_t [NUM_SLOTS-1:0]    disp_ndx_o,
	output func_unit_t [NUM_SLOTS-1:0]  disp_unit_o,
	output op_class_t [NUM_SLOTS-1:0]   disp_cls_o,
	output pc_t [NUM_SLOTS-1:0]         disp_pc_o,
	output logic                        commit_v_o,
	output rob_ndx_t                    commit_ndx_o,
	output pc_t                         commit_pc_o
);

	// buffer state seen by the dispatcher
	rob_ndx_t              head;
	logic [DEPTH-1:0]      rob_v;
	op_class_t [DEPTH-1:0] rob_cls;
	pc_t [DEPTH-1:0]       rob_pc;
	logic [DEPTH-1:0]      rob_pred_v;
	logic [DEPTH-1:0]      rob_pred;
	logic [DEPTH-1:0]      rob_out;
	logic [DEPTH-1:0]      rob_done;
	// tracker results
	logic [NUM_UNITS-1:0]  unit_busy;
	logic                  done_v;
	rob_ndx_t              done_ndx;

	reorder_buffer #(
		.DEPTH(DEPTH)
	) rob0 (
		.clk(clk),
		.rst(rst),
		.alloc_v_i(alloc_v_i),
		.alloc_cls_i(alloc_cls_i),
		.alloc_pc_i(alloc_pc_i),
		.alloc_pred_v_i(alloc_pred_v_i),
		.alloc_pred_i(alloc_pred_i),
		.pred_set_v_i(pred_set_v_i),
		.pred_set_ndx_i(pred_set_ndx_i),
		.pred_set_val_i(pred_set_val_i),
		.disp_v_i(disp_v_o),
		.disp_ndx_i(disp_ndx_o),
		.done_v_i(done_v),
		.done_ndx_i(done_ndx),
		.alloc_ready_o(alloc_ready_o),
		.head_o(head),
		.rob_v_o(rob_v),
		.rob_cls_o(rob_cls),
		.rob_pc_o(rob_pc),
		.rob_pred_v_o(rob_pred_v),
		.rob_pred_o(rob_pred),
		.rob_out_o(rob_out),
		.rob_done_o(rob_done),
		.commit_v_o(commit_v_o),
		.commit_ndx_o(commit_ndx_o),
		.commit_pc_o(commit_pc_o)
	);

	instruction_dispatcher #(
		.DEPTH(DEPTH),
		.SERIALIZE(SERIALIZE)
	) disp0 (
		.clk(clk),
		.rst(rst),
		.head_i(head),
		.rob_v_i(rob_v),
		.rob_cls_i(rob_cls),
		.rob_pc_i(rob_pc),
		.rob_pred_v_i(rob_pred_v),
		.rob_pred_i(rob_pred),
		.rob_out_i(rob_out),
		.rob_done_i(rob_done),
		.stomp_i(stomp_i),
		.unit_busy_i(unit_busy),
		.disp_v_o(disp_v_o),
		.disp_ndx_o(disp_ndx_o),
		.disp_unit_o(disp_unit_o),
		.disp_cls_o(disp_cls_o),
		.disp_pc_o(disp_pc_o)
	);

	// slot records reserve units here one edge after they appear
	unit_busy_tracker busy0 (
		.clk(clk),
		.rst(rst),
		.disp_v_i(disp_v_o),
		.disp_unit_i(disp_unit_o),
		.disp_ndx_i(disp_ndx_o),
		.complete_v_i(complete_v_i),
		.complete_unit_i(complete_unit_i),
		.unit_busy_o(unit_busy),
		.done_v_o(done_v),
		.done_ndx_o(done_ndx)
	);

endmodule

// File: sim/tb_checks.svh
/*
 * compare tasks for the dispatch testbench
 * one task per result type, each reports a mismatch and counts it
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got %0b expected %0b", $time, name, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_ndx(input string name, input rob_ndx_t got, input rob_ndx_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_unit(input string name, input func_unit_t got,
		input func_unit_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_cls(input string name, input op_class_t got, input op_class_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got %04h expected %04h", $time, name, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

`endif

// File: sim/tb_dispatch.sv
/*
 * dispatch stage testbench
 * reads commands from a data file, drives the stage and checks dispatch
 * records, commit records and the allocation ready flag
 */

`timescale 1ns/1ps

module tb_dispatch import dispatch_pkg::*; ();

	localparam int TIMEOUT = 100;

	logic clk = 1'b0;
	logic rst;
	logic alloc_v_i;
	op_class_t alloc_cls_i;
	pc_t alloc_pc_i;
	logic alloc_pred_v_i;
	logic alloc_pred_i;
	logic alloc_ready_o;
	logic pred_set_v_i;
	rob_ndx_t pred_set_ndx_i;
	logic pred_set_val_i;
	logic [7:0] stomp_i;
	logic complete_v_i;
	func_unit_t complete_unit_i;
	logic [NUM_SLOTS-1:0] disp_v_o;
	rob_ndx_t [NUM_SLOTS-1:0] disp_ndx_o;
	func_unit_t [NUM_SLOTS-1:0] disp_unit_o;
	op_class_t [NUM_SLOTS-1:0] disp_cls_o;
	pc_t [NUM_SLOTS-1:0] disp_pc_o;
	logic commit_v_o;
	rob_ndx_t commit_ndx_o;
	pc_t commit_pc_o;

	int errors = 0;
	int tests = 0;
	logic test_bad;
	logic [31:0] seed = 32'h28a56987;

	// every observed slot record in arrival order
	slot_t mq_slot[$];
	rob_ndx_t mq_ndx[$];
	func_unit_t mq_unit[$];
	op_class_t mq_cls[$];
	pc_t mq_pc[$];
	// observed commit records
	rob_ndx_t cq_ndx[$];
	pc_t cq_pc[$];
	// dispatches per unit that have not been completed yet
	int pending[NUM_UNITS];

	`include "tb_checks.svh"

	dispatch_top #(
		.DEPTH(8),
		.SERIALIZE(0)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.alloc_v_i(alloc_v_i),
		.alloc_cls_i(alloc_cls_i),
		.alloc_pc_i(alloc_pc_i),
		.alloc_pred_v_i(alloc_pred_v_i),
		.alloc_pred_i(alloc_pred_i),
		.alloc_ready_o(alloc_ready_o),
		.pred_set_v_i(pred_set_v_i),
		.pred_set_ndx_i(pred_set_ndx_i),
		.pred_set_val_i(pred_set_val_i),
		.stomp_i(stomp_i),
		.complete_v_i(complete_v_i),
		.complete_unit_i(complete_unit_i),
		.disp_v_o(disp_v_o),
		.disp_ndx_o(disp_ndx_o),
		.disp_unit_o(disp_unit_o),
		.disp_cls_o(disp_cls_o),
		.disp_pc_o(disp_pc_o),
		.commit_v_o(commit_v_o),
		.commit_ndx_o(commit_ndx_o),
		.commit_pc_o(commit_pc_o)
	);

	always #2 clk = ~clk;

	// ==============================
	// monitor
	// ==============================

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (disp_v_o[s]) begin
					mq_slot.push_back(slot_t'(2'(s)));
					mq_ndx.push_back(disp_ndx_o[s]);
					mq_unit.push_back(disp_unit_o[s]);
					mq_cls.push_back(disp_cls_o[s]);
					mq_pc.push_back(disp_pc_o[s]);
					pending[int'(disp_unit_o[s])]++;
					// a reserved unit must not take a second entry before it completes
					if (pending[int'(disp_unit_o[s])] > 1) begin
						$display("unit %0d took a second entry before it completed",
							int'(disp_unit_o[s]));
						errors++;
					end
				end
			end
			if (commit_v_o) begin
				cq_ndx.push_back(commit_ndx_o);
				cq_pc.push_back(commit_pc_o);
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1664525 + 32'd1013904223;
	endfunction

	// position of the oldest recorded dispatch on a slot or -1 when there is none
	function automatic int find_slot(input slot_t sl);
		find_slot = -1;
		for (int i = 0; i < mq_slot.size(); i++) begin
			if (find_slot < 0 && mq_slot[i] == sl)
				find_slot = i;
		end
	endfunction

	// ==============================
	// drivers
	// ==============================

	task automatic drive_alloc(input op_class_t cls, input pc_t pc, input logic pv,
		input logic p);
		@(posedge clk);
		alloc_v_i <= 1'b1;
		alloc_cls_i <= cls;
		alloc_pc_i <= pc;
		alloc_pred_v_i <= pv;
		alloc_pred_i <= p;
		@(posedge clk);
		alloc_v_i <= 1'b0;
	endtask

	task automatic drive_pred(input rob_ndx_t ndx, input logic val);
		@(posedge clk);
		pred_set_v_i <= 1'b1;
		pred_set_ndx_i <= ndx;
		pred_set_val_i <= val;
		@(posedge clk);
		pred_set_v_i <= 1'b0;
	endtask

	// a unit only takes a completion once something was sent to it
	task automatic drive_complete(input func_unit_t unit, output logic ok);
		int n;
		n = 0;
		@(posedge clk);
		while (pending[int'(unit)] == 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		ok = (pending[int'(unit)] != 0);
		if (ok) begin
			pending[int'(unit)]--;
			complete_v_i <= 1'b1;
			complete_unit_i <= unit;
			@(posedge clk);
			complete_v_i <= 1'b0;
		end
	endtask

	// ==============================
	// expectations
	// ==============================

	task automatic expect_dispatch(input slot_t sl, input rob_ndx_t ndx, input func_unit_t unit,
		input op_class_t cls, input pc_t pc, output logic ok);
		int n;
		int i;
		n = 0;
		i = find_slot(sl);
		while (i < 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			i = find_slot(sl);
		end
		ok = (i >= 0);
		if (ok) begin
			check_ndx("disp_ndx_o", mq_ndx[i], ndx);
			check_unit("disp_unit_o", mq_unit[i], unit);
			check_cls("disp_cls_o", mq_cls[i], cls);
			check_pc("disp_pc_o", mq_pc[i], pc);
			mq_slot.delete(i);
			mq_ndx.delete(i);
			mq_unit.delete(i);
			mq_cls.delete(i);
			mq_pc.delete(i);
		end
	endtask

	task automatic expect_commit(input rob_ndx_t ndx, input pc_t pc, output logic ok);
		int n;
		n = 0;
		while (cq_ndx.size() == 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		ok = (cq_ndx.size() != 0);
		if (ok) begin
			check_ndx("commit_ndx_o", cq_ndx.pop_front(), ndx);
			check_pc("commit_pc_o", cq_pc.pop_front(), pc);
		end
	endtask

	// ==============================
	// command loop
	// ==============================

	initial begin
		int fd;
		int a;
		int b;
		int c;
		int d;
		int e;
		byte cmd;
		string line;
		logic ok;
		logic timed_out;

		alloc_v_i = 1'b0;
		alloc_cls_i = OC_ALU;
		alloc_pc_i = '0;
		alloc_pred_v_i = 1'b0;
		alloc_pred_i = 1'b0;
		pred_set_v_i = 1'b0;
		pred_set_ndx_i = '0;
		pred_set_val_i = 1'b0;
		stomp_i = '0;
		complete_v_i = 1'b0;
		complete_unit_i = FU_ALU0;
		timed_out = 1'b0;
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// idle stage right after reset
		test_bad = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_flag("disp_v_o", |disp_v_o, 1'b0);
			check_flag("commit_v_o", commit_v_o, 1'b0);
			check_flag("alloc_ready_o", alloc_ready_o, 1'b1);
		end
		tests++;
		$display("test %0d reset %s", tests, test_bad ? "mismatch" : "ok");

		fd = $fopen("sim/dispatch_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			errors++;
			timed_out = 1'b1;
		end
		while (!timed_out && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			e = 0;
			void'($sscanf(line, "%c %h %h %h %h %h", cmd, a, b, c, d, e));
			seed = lcg_next(seed);
			repeat (int'(seed[17:16])) @(posedge clk);
			test_bad = 1'b0;
			ok = 1'b1;
			case (cmd)
				"A": drive_alloc(op_class_t'(a[2:0]), pc_t'(b[15:0]), c[0], d[0]);
				"P": drive_pred(rob_ndx_t'(a[2:0]), b[0]);
				"S": begin
					@(posedge clk);
					stomp_i <= a[7:0];
				end
				"C": drive_complete(func_unit_t'(a[2:0]), ok);
				"D": expect_dispatch(slot_t'(a[1:0]), rob_ndx_t'(b[2:0]),
					func_unit_t'(c[2:0]), op_class_t'(d[2:0]), pc_t'(e[15:0]), ok);
				"M": expect_commit(rob_ndx_t'(a[2:0]), pc_t'(b[15:0]), ok);
				"F": begin
					@(negedge clk);
					check_flag("alloc_ready_o", alloc_ready_o, a[0]);
				end
				default: begin
					$display("unknown command in the test data file");
					errors++;
				end
			endcase
			if (!ok) begin
				$display("timeout after %0d cycles on command %c", TIMEOUT, cmd);
				errors++;
				timed_out = 1'b1;
			end else if (cmd == "D" || cmd == "M" || cmd == "F") begin
				tests++;
				$display("test %0d %c %s", tests, cmd, test_bad ? "mismatch" : "ok");
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests %0d errors %0d", tests, errors);
		if (errors == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+sim
logic/dispatch_pkg.sv
logic/reorder_buffer.sv
logic/instruction_dispatcher.sv
logic/unit_busy_tracker.sv
logic/dispatch_top.sv
sim/tb_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# build the dispatch stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_dispatch -o tb_dispatch

./obj_dir/tb_dispatch | tee sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: sim/dispatch_tests.txt
# A cls pc pred_v pred | P ndx val | S mask | C unit | F ready
# D slot ndx unit cls pc | M ndx pc  (all values hex)
F 1
A 0 100 1 1
A 0 104 1 1
A 1 108 1 1
A 2 10c 1 1
A 3 110 1 1
A 4 114 1 1
D 0 0 0 0 100
D 0 1 1 0 104
D 1 2 2 1 108
D 2 4 3 3 110
D 3 5 4 4 114
C 2
D 1 3 2 2 10c
C 4
C 3
C 1
C 0
C 2
M 0 100
M 1 104
M 2 108
M 3 10c
M 4 110
M 5 114
# oldest first behind a busy unit
A 1 200 1 1
A 2 204 1 1
A 2 208 1 1
A 4 20c 1 1
D 1 6 2 1 200
D 3 1 4 4 20c
C 2
D 1 7 2 2 204
C 2
D 1 0 2 2 208
C 2
C 4
M 6 200
M 7 204
M 0 208
M 1 20c
# predicates and stomp
S 10
A 0 300 0 0
A 3 304 1 0
A 4 308 1 1
D 2 3 3 5 304
D 3 4 4 5 308
S 0
P 2 1
D 0 2 0 0 300
C 3
C 4
C 0
M 2 300
M 3 304
M 4 308
# full buffer
A 0 400 0 0
A 0 404 0 0
A 0 408 0 0
A 0 40c 0 0
A 0 410 0 0
A 0 414 0 0
A 0 418 0 0
A 0 41c 0 0
F 0
A 0 4f0 1 1
F 0
P 5 1
P 6 1
P 7 1
P 0 1
P 1 1
P 2 1
P 3 1
P 4 1
C 0
C 1
C 0
C 1
C 0
C 1
C 0
C 1
M 5 400
M 6 404
M 7 408
M 0 40c
M 1 410
M 2 414
M 3 418
M 4 41c
F 1
A 0 500 1 1
C 0
M 5 500
